// File: vu_macros.svh
/*
 * Vector unit build parameters
 * Lane count, data width and register count shared by the packages and RTL
 */
`ifndef VU_MACROS_SVH
`define VU_MACROS_SVH

//////////////////////////////////////////////////
// Lane organisation
//////////////////////////////////////////////////
`define VU_NUM_LANES	4	// Power of two, one bit per lane in masks
`define VU_NUM_REGS	8	// Registers in each lane

//////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////
`define VU_DATA_W	16	// Operand width, all arithmetic wraps here

`endif

// File: vu_types_pkg.sv
/*
 * Vector unit data types
 * Operand words, per-lane bit vectors and the index types
 */
`default_nettype none

`include "vu_macros.svh"

package vu_types_pkg;

	// One lane operand or result
	typedef logic [`VU_DATA_W-1:0]			data_t;

	// One bit per lane for mask, commit and status
	typedef logic [`VU_NUM_LANES-1:0]		lane_t;

	// Register index inside one lane
	typedef logic [$clog2(`VU_NUM_REGS)-1:0]	reg_idx_t;

	// Lane number, also the scalar select
	typedef logic [$clog2(`VU_NUM_LANES)-1:0]	lane_idx_t;

endpackage

`default_nettype wire

// File: vu_cmd_pkg.sv
/*
 * Vector unit command encoding
 * Opcode field width and the opcode set run by every lane
 */
`default_nettype none

package vu_cmd_pkg;

	localparam int OP_W = 3;	// Opcode field width

	//////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////
	// All eight codes are used, so every value decodes
	typedef enum logic [OP_W-1:0] {
		op_add		= 3'd0,	// src1 + src2
		op_sub		= 3'd1,	// src1 - src2
		op_and		= 3'd2,	// Bitwise and
		op_xor		= 3'd3,	// Bitwise xor
		op_mul		= 3'd4,	// Low half of the product
		op_mac		= 3'd5,	// Low half of the product plus src3
		op_bcast	= 3'd6,	// Scalar input to every lane
		op_rotl		= 3'd7	// src1 of the next lane up
	} opcode_t;

endpackage

`default_nettype wire

// File: lane_regfile.sv
/*
 * Lane register file
 * VU_NUM_REGS words with three combinational read ports and one write port
 */
`default_nettype none

`include "vu_macros.svh"

module lane_regfile (
	input  wire logic			clock,
	input  wire logic			rst_n,
	input  wire logic			wr_en,		// Write-back strobe
	input  wire vu_types_pkg::reg_idx_t	wr_idx,
	input  wire vu_types_pkg::data_t	wr_data,
	input  wire vu_types_pkg::reg_idx_t	rd_idx1,
	input  wire vu_types_pkg::reg_idx_t	rd_idx2,
	input  wire vu_types_pkg::reg_idx_t	rd_idx3,
	output vu_types_pkg::data_t		rd_data1,
	output vu_types_pkg::data_t		rd_data2,
	output vu_types_pkg::data_t		rd_data3
);
	import vu_types_pkg::*;

	data_t	regs [`VU_NUM_REGS];

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `VU_NUM_REGS; i++) begin
				regs[i] <= '0;	// All registers read zero after reset
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	//////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////
	assign rd_data1 = regs[rd_idx1];
	assign rd_data2 = regs[rd_idx2];
	assign rd_data3 = regs[rd_idx3];

endmodule

`default_nettype wire

// File: lane_alu.sv
/*
 * Lane ALU
 * Combinational result for every opcode, wrapping at the data width,
 * together with a zero flag
 */
`default_nettype none

module lane_alu (
	input  wire vu_cmd_pkg::opcode_t	op,
	input  wire vu_types_pkg::data_t	src1,
	input  wire vu_types_pkg::data_t	src2,
	input  wire vu_types_pkg::data_t	src3,
	input  wire vu_types_pkg::data_t	scalar,		// Broadcast value
	input  wire vu_types_pkg::data_t	neighbour,	// src1 of the next lane
	output vu_types_pkg::data_t		result,
	output logic				zero
);
	import vu_types_pkg::*;
	import vu_cmd_pkg::*;

	data_t	product;	// Low half of src1 * src2

	// Shared by op_mul and op_mac, truncated by the assignment width
	assign product = src1 * src2;

	//////////////////////////////////////////////////
	// Opcode decode
	//////////////////////////////////////////////////
	always_comb begin
		unique case (op)
			op_add:		result = src1 + src2;
			op_sub:		result = src1 - src2;
			op_and:		result = src1 & src2;
			op_xor:		result = src1 ^ src2;
			op_mul:		result = product;
			op_mac:		result = product + src3;	// Wraps like the rest
			op_bcast:	result = scalar;
			op_rotl:	result = neighbour;
		endcase
	end

	assign zero = (result == '0);	// Feeds the lane status bit

endmodule

`default_nettype wire

// File: lane_unit.sv
/*
 * One SIMT lane
 * Register read with forwarding, operand stage, ALU stage and write-back.
 * Source 1 is published on the cross-lane bus for op_rotl.
 */
`default_nettype none

`include "vu_macros.svh"

module lane_unit #(
	parameter int LANE_ID = 0
) (
	input  wire logic					clock,
	input  wire logic					rst_n,
	input  wire logic					cmd_valid,	// Single-cycle strobe
	input  wire logic					en,		// Mask bit of the write-back command
	input  wire vu_cmd_pkg::opcode_t			cmd_op,
	input  wire vu_types_pkg::reg_idx_t			cmd_rd,
	input  wire vu_types_pkg::reg_idx_t			cmd_rs1,
	input  wire vu_types_pkg::reg_idx_t			cmd_rs2,
	input  wire vu_types_pkg::reg_idx_t			cmd_rs3,
	input  wire vu_types_pkg::data_t			scalar_in,
	input  wire vu_types_pkg::data_t [`VU_NUM_LANES-1:0]	lane_src1_bus,
	output vu_types_pkg::data_t				lane_src1,	// Our entry of the bus
	output vu_types_pkg::data_t				result,		// ALU output, operand stage
	output logic						commit,
	output logic						status
);
	import vu_types_pkg::*;
	import vu_cmd_pkg::*;

	localparam int NEXT_LANE = (LANE_ID + 1) % `VU_NUM_LANES;

	// Register read
	data_t		rf_rd1, rf_rd2, rf_rd3;
	data_t		rd_fwd1, rd_fwd2, rd_fwd3;

	// Operand stage
	logic		op_vld;
	opcode_t	op_q;
	reg_idx_t	op_rd, op_rs1, op_rs2, op_rs3;
	data_t		op_src1, op_src2, op_src3, op_scalar;
	data_t		ex_src1, ex_src2, ex_src3;
	logic		alu_zero;

	// Write-back stage
	logic		wb_vld;
	reg_idx_t	wb_rd;
	data_t		wb_data;
	logic		wb_zero;
	logic		wb_we;
	logic		status_q;

	assign wb_we = wb_vld & en;	// Disabled lanes write nothing

	lane_regfile u_regfile (
		.clock		(clock),
		.rst_n		(rst_n),
		.wr_en		(wb_we),
		.wr_idx		(wb_rd),
		.wr_data	(wb_data),
		.rd_idx1	(cmd_rs1),
		.rd_idx2	(cmd_rs2),
		.rd_idx3	(cmd_rs3),
		.rd_data1	(rf_rd1),
		.rd_data2	(rf_rd2),
		.rd_data3	(rf_rd3)
	);

	//////////////////////////////////////////////////
	// Forwarding from write-back
	//////////////////////////////////////////////////
	// At read time the write-back holds the command two ahead
	assign rd_fwd1 = (wb_we && wb_rd == cmd_rs1) ? wb_data : rf_rd1;
	assign rd_fwd2 = (wb_we && wb_rd == cmd_rs2) ? wb_data : rf_rd2;
	assign rd_fwd3 = (wb_we && wb_rd == cmd_rs3) ? wb_data : rf_rd3;

	// In the operand stage it holds the command right ahead
	assign ex_src1 = (wb_we && wb_rd == op_rs1) ? wb_data : op_src1;
	assign ex_src2 = (wb_we && wb_rd == op_rs2) ? wb_data : op_src2;
	assign ex_src3 = (wb_we && wb_rd == op_rs3) ? wb_data : op_src3;

	assign lane_src1 = ex_src1;

	//////////////////////////////////////////////////
	// Operand stage
	//////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			op_vld <= 1'b0;
		end else begin
			op_vld <= cmd_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (cmd_valid) begin
			op_q		<= cmd_op;
			op_rd		<= cmd_rd;
			op_rs1		<= cmd_rs1;
			op_rs2		<= cmd_rs2;
			op_rs3		<= cmd_rs3;
			op_src1		<= rd_fwd1;
			op_src2		<= rd_fwd2;
			op_src3		<= rd_fwd3;
			op_scalar	<= scalar_in;
		end
	end

	lane_alu u_alu (
		.op		(op_q),
		.src1		(ex_src1),
		.src2		(ex_src2),
		.src3		(ex_src3),
		.scalar		(op_scalar),
		.neighbour	(lane_src1_bus[NEXT_LANE]),
		.result		(result),
		.zero		(alu_zero)
	);

	//////////////////////////////////////////////////
	// Write-back stage
	//////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wb_vld		<= 1'b0;
			status_q	<= 1'b0;
		end else begin
			wb_vld <= op_vld;
			if (wb_we) begin
				status_q <= wb_zero;	// Held while the lane is masked off
			end
		end
	end

	always_ff @(posedge clock) begin
		if (op_vld) begin
			wb_rd	<= op_rd;
			wb_data	<= result;
			wb_zero	<= alu_zero;
		end
	end

	// Every lane commits, the top compares against the mask
	assign commit = wb_vld;
	assign status = wb_we ? wb_zero : status_q;

endmodule

`default_nettype wire

// File: vector_unit.sv
/*
 * SIMT vector unit top level
 * NUM_LANES lanes sharing one command strobe, cross-lane source bus,
 * commit reduction and scalar result select
 */
`default_nettype none

`include "vu_macros.svh"

module vector_unit (
	input  wire logic			clock,
	input  wire logic			rst_n,
	input  wire logic			cmd_valid,	// One command per strobe
	input  wire vu_cmd_pkg::opcode_t	cmd_op,
	input  wire vu_types_pkg::reg_idx_t	cmd_rd,
	input  wire vu_types_pkg::reg_idx_t	cmd_rs1,
	input  wire vu_types_pkg::reg_idx_t	cmd_rs2,
	input  wire vu_types_pkg::reg_idx_t	cmd_rs3,
	input  wire vu_types_pkg::lane_t	en_lane,	// Write-back enable per lane
	input  wire vu_types_pkg::data_t	scalar_in,	// Broadcast data and lane select
	output vu_types_pkg::data_t		scalar_out,
	output logic				commit_req,
	output vu_types_pkg::lane_t		status
);
	import vu_types_pkg::*;

	data_t [`VU_NUM_LANES-1:0]	lane_src1_bus;
	data_t [`VU_NUM_LANES-1:0]	lane_result;
	lane_t				commit;

	// Command side info carried alongside the lane pipeline
	logic		vld_s1, vld_s2;
	lane_t		mask_s1, mask_s2;
	lane_idx_t	sel_s1;

	//////////////////////////////////////////////////
	// Lane array
	//////////////////////////////////////////////////
	for (genvar i = 0; i < `VU_NUM_LANES; i++) begin : g_lane
		lane_unit #(
			.LANE_ID	(i)
		) u_lane (
			.clock		(clock),
			.rst_n		(rst_n),
			.cmd_valid	(cmd_valid),
			.en		(mask_s2[i]),
			.cmd_op		(cmd_op),
			.cmd_rd		(cmd_rd),
			.cmd_rs1	(cmd_rs1),
			.cmd_rs2	(cmd_rs2),
			.cmd_rs3	(cmd_rs3),
			.scalar_in	(scalar_in),
			.lane_src1_bus	(lane_src1_bus),
			.lane_src1	(lane_src1_bus[i]),
			.result		(lane_result[i]),
			.commit		(commit[i]),
			.status		(status[i])
		);
	end

	//////////////////////////////////////////////////
	// Mask, select and result pipeline
	//////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			vld_s1		<= 1'b0;
			vld_s2		<= 1'b0;
			mask_s1		<= '0;
			mask_s2		<= '0;
			sel_s1		<= '0;
			scalar_out	<= '0;
		end else begin
			vld_s1	<= cmd_valid;
			vld_s2	<= vld_s1;
			mask_s2	<= mask_s1;
			if (cmd_valid) begin
				mask_s1	<= en_lane;
				sel_s1	<= scalar_in[$bits(lane_idx_t)-1:0];	// Low bits pick the lane
			end
			if (vld_s1) begin
				scalar_out <= lane_result[sel_s1];	// Lines up with write-back
			end
		end
	end

	// Every enabled lane committed; an empty mask commits at once
	assign commit_req = vld_s2 & (&(commit | ~mask_s2));

endmodule

`default_nettype wire

// File: tb_vector_unit.sv
/*
 * Vector unit testbench
 * Drives command streams into the DUT, predicts every lane with a model
 * register file and checks scalar_out, status and commit timing
 */
`default_nettype none

`include "vu_macros.svh"

module tb_vector_unit;
	import vu_types_pkg::*;
	import vu_cmd_pkg::*;

	localparam int N		= `VU_NUM_LANES;
	localparam int COMMIT_DELAY	= 3;	// Falling edges from driving edge to commit
	localparam int DRAIN_LIMIT	= 20;	// Cycles allowed for the last commits

	typedef struct packed {
		int unsigned	due;		// Falling edge count of the commit
		data_t		scalar;
		lane_t		status;
	} expect_t;

	logic		clock;
	logic		rst_n;
	logic		cmd_valid;
	opcode_t	cmd_op;
	reg_idx_t	cmd_rd, cmd_rs1, cmd_rs2, cmd_rs3;
	lane_t		en_lane;
	data_t		scalar_in;
	data_t		scalar_out;
	logic		commit_req;
	lane_t		status;

	data_t		model_regs [N][`VU_NUM_REGS];
	lane_t		model_status;
	expect_t	exp_q [$];
	int unsigned	cycle_cnt = 0;
	int unsigned	strobe_cnt = 0;
	int unsigned	commit_cnt = 0;

	vector_unit UUT (
		.clock		(clock),
		.rst_n		(rst_n),
		.cmd_valid	(cmd_valid),
		.cmd_op		(cmd_op),
		.cmd_rd		(cmd_rd),
		.cmd_rs1	(cmd_rs1),
		.cmd_rs2	(cmd_rs2),
		.cmd_rs3	(cmd_rs3),
		.en_lane	(en_lane),
		.scalar_in	(scalar_in),
		.scalar_out	(scalar_out),
		.commit_req	(commit_req),
		.status		(status)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////
	function automatic data_t predict_lane(input opcode_t op, input data_t s1, s2, s3,
			scalar, neighbour);
		logic [2*`VU_DATA_W-1:0]	full;
		full = (2*`VU_DATA_W)'(s1) * (2*`VU_DATA_W)'(s2);	// Full product
		case (op)
			op_add:		return s1 + s2;
			op_sub:		return s1 - s2;
			op_and:		return s1 & s2;
			op_xor:		return s1 ^ s2;
			op_mul:		return full[`VU_DATA_W-1:0];
			op_mac:		return full[`VU_DATA_W-1:0] + s3;
			op_bcast:	return scalar;
			default:	return neighbour;	// op_rotl
		endcase
	endfunction

	// Low bits pick the lane and the rest stay random
	function automatic data_t lane_scalar(input int l);
		data_t	s;
		s = data_t'($urandom);
		s[$bits(lane_idx_t)-1:0] = lane_idx_t'(l);
		return s;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "stopped at the first error");
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	task automatic issue(input opcode_t op, input reg_idx_t rd, rs1, rs2, rs3,
			input lane_t mask, input data_t scalar);
		data_t		res [N];
		expect_t	e;
		@(posedge clock);
		cmd_valid	<= 1'b1;
		cmd_op		<= op;
		cmd_rd		<= rd;
		cmd_rs1		<= rs1;
		cmd_rs2		<= rs2;
		cmd_rs3		<= rs3;
		en_lane		<= mask;
		scalar_in	<= scalar;
		for (int i = 0; i < N; i++) begin
			res[i] = predict_lane(op, model_regs[i][rs1], model_regs[i][rs2],
				model_regs[i][rs3], scalar, model_regs[(i+1)%N][rs1]);
		end
		for (int i = 0; i < N; i++) begin
			if (mask[i]) begin
				model_regs[i][rd] = res[i];
				model_status[i] = (res[i] == '0);
			end
		end
		e.due = cycle_cnt + COMMIT_DELAY;
		e.scalar = res[scalar[$bits(lane_idx_t)-1:0]];
		e.status = model_status;
		exp_q.push_back(e);
	endtask

	task automatic idle_cycle();
		@(posedge clock);
		cmd_valid <= 1'b0;
	endtask

	task automatic random_cmd(input lane_t mask);
		issue(opcode_t'($urandom_range(7, 0)), reg_idx_t'($urandom), reg_idx_t'($urandom),
			reg_idx_t'($urandom), reg_idx_t'($urandom), mask, data_t'($urandom));
	endtask

	// Masked-off and of a register with itself writes nothing
	task automatic read_all();
		for (int r = 0; r < `VU_NUM_REGS; r++) begin
			for (int l = 0; l < N; l++) begin
				issue(op_and, reg_idx_t'($urandom), reg_idx_t'(r), reg_idx_t'(r),
					reg_idx_t'(r), '0, lane_scalar(l));
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Comparison
	//////////////////////////////////////////////////
	initial begin
		expect_t	e;
		forever begin
			@(negedge clock);
			cycle_cnt++;
			if (rst_n && cmd_valid) begin
				strobe_cnt++;	// Sampled by the DUT at the next rising edge
			end
			if (rst_n && commit_req) begin
				commit_cnt++;
				assert (exp_q.size() > 0) else
					stop_on_error("commit_req pulsed with no command in flight");
				e = exp_q.pop_front();
				assert (cycle_cnt == e.due) else
					stop_on_error($sformatf("commit_req came at cycle %0d instead of %0d",
						cycle_cnt, e.due));
				assert (scalar_out == e.scalar) else
					stop_on_error($sformatf("error scalar_out got %h expected %h",
						scalar_out, e.scalar));
				assert (status == e.status) else
					stop_on_error($sformatf("error status got %h expected %h",
						status, e.status));
			end else if (rst_n && exp_q.size() > 0) begin
				assert (exp_q[0].due > cycle_cnt) else
					stop_on_error("commit_req did not come for an issued command");
			end
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial begin
		opcode_t	arith_ops [6] = '{op_add, op_sub, op_and, op_xor, op_mul, op_mac};
		reg_idx_t	dep_rd, next_rd;
		void'($urandom(32'hfdb1));
		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_op = op_add;
		cmd_rd = '0;
		cmd_rs1 = '0;
		cmd_rs2 = '0;
		cmd_rs3 = '0;
		en_lane = '0;
		scalar_in = '0;
		model_status = '0;
		for (int i = 0; i < N; i++) begin
			for (int r = 0; r < `VU_NUM_REGS; r++) begin
				model_regs[i][r] = '0;
			end
		end
		repeat (8) @(posedge clock);
		rst_n <= 1'b1;
		@(negedge clock);
		assert (commit_req == 1'b0) else
			stop_on_error($sformatf("error commit_req got %h expected 0", commit_req));
		assert (status == '0) else
			stop_on_error($sformatf("error status got %h expected 0", status));

		issue(op_add, 0, 1, 2, 3, '1, lane_scalar(0));	// Zero registers give every status bit set
		idle_cycle();

		// Distinct values per lane and register
		for (int r = 0; r < `VU_NUM_REGS; r++) begin
			for (int l = 0; l < N; l++) begin
				issue(op_bcast, reg_idx_t'(r), 0, 0, 0, lane_t'(1) << l, data_t'($urandom));
			end
		end
		read_all();
		foreach (arith_ops[k]) begin
			issue(arith_ops[k], reg_idx_t'($urandom), reg_idx_t'($urandom),
				reg_idx_t'($urandom), reg_idx_t'($urandom), '1, lane_scalar(k % N));
		end
		read_all();

		// Each command reads the destination of the one before
		dep_rd = reg_idx_t'($urandom);
		repeat (24) begin
			next_rd = reg_idx_t'($urandom);
			issue(arith_ops[$urandom_range(5, 0)], next_rd, dep_rd, dep_rd,
				reg_idx_t'($urandom), '1, lane_scalar($urandom_range(N-1, 0)));
			if ($urandom_range(3, 0) == 0) idle_cycle();
			dep_rd = next_rd;
		end

		repeat (40) random_cmd(lane_t'($urandom));
		read_all();

		// Rotate reads without writing and then one rotate that writes
		for (int r = 0; r < `VU_NUM_REGS; r++) begin
			for (int l = 0; l < N; l++) begin
				issue(op_rotl, reg_idx_t'(r), reg_idx_t'(r), 0, 0, '0, lane_scalar(l));
			end
		end
		issue(op_rotl, 0, 0, 0, 0, '1, lane_scalar(1));
		read_all();

		repeat (300) begin
			random_cmd(lane_t'($urandom));
			if ($urandom_range(3, 0) == 0) idle_cycle();
		end
		read_all();

		idle_cycle();
		for (int t = 0; t < DRAIN_LIMIT && exp_q.size() > 0; t++) begin
			@(negedge clock);
		end
		assert (exp_q.size() == 0) else
			stop_on_error("timeout while waiting for the last commits");
		assert (commit_cnt == strobe_cnt) else
			stop_on_error($sformatf("error commit_req count got %h expected %h",
				commit_cnt, strobe_cnt));
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
vu_types_pkg.sv
vu_cmd_pkg.sv
lane_regfile.sv
lane_alu.sv
lane_unit.sv
vector_unit.sv
tb_vector_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the vector unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_vector_unit \
	-f list.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_vector_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
